/* verilog/poolGeometryPkg.sv */
package poolGeometryPkg;

	//////////////////////////////////////////////////////////////////////
	// input frame
	//////////////////////////////////////////////////////////////////////

	// raster columns per input row
	localparam int frameWidth = 24;
	localparam int frameHeight = 24;

	//////////////////////////////////////////////////////////////////////
	// pooled frame
	//////////////////////////////////////////////////////////////////////

	// one lane per output column
	localparam int laneCount = 12;
	localparam int outRows = 12;
	localparam int outPixelsPerFrame = 144;

	//////////////////////////////////////////////////////////////////////
	// counter widths
	//////////////////////////////////////////////////////////////////////

	localparam int colWidth = 5;
	// lane index is the column without its low bit
	localparam int laneSelWidth = 4;
	localparam int outCountWidth = 8;

endpackage

/* verilog/pixelFormatPkg.sv */
package pixelFormatPkg;

	//////////////////////////////////////////////////////////////////////
	// pixel word
	//////////////////////////////////////////////////////////////////////

	localparam int pixelWidth = 16;

	//////////////////////////////////////////////////////////////////////
	// window arithmetic
	//////////////////////////////////////////////////////////////////////

	// four full-scale pixels need two extra bits
	localparam int sumWidth = 18;

	// divide by the four window pixels
	localparam int avgShift = 2;

	// floored average without rounding

endpackage

/* verilog/rasterScanner.sv */
module rasterScanner
(
	input  logic Clock,
	input  logic rstN,

	input  logic [pixelFormatPkg::pixelWidth-1:0] pixelIn,
	input  logic pixelReq,
	output logic pixelAck,

	output logic [poolGeometryPkg::laneCount-1:0] laneAdd,
	output logic [pixelFormatPkg::pixelWidth-1:0] laneData,
	input  logic [poolGeometryPkg::laneCount-1:0] laneReady
);

	logic [poolGeometryPkg::colWidth-1:0] col;
	logic [poolGeometryPkg::laneSelWidth-1:0] laneSel;
	logic lastCol;
	logic accept;

	//////////////////////////////////////////////////////////////////////
	// column tracking
	//////////////////////////////////////////////////////////////////////

	// two neighbouring columns share a lane
	assign laneSel = col[poolGeometryPkg::colWidth-1:1];

	assign lastCol = (col == poolGeometryPkg::colWidth'(poolGeometryPkg::frameWidth - 1));

	// take a new pixel only from an idle handshake into a ready lane
	assign accept = pixelReq && !pixelAck && laneReady[laneSel];

	//////////////////////////////////////////////////////////////////////
	// input handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			pixelAck <= 1'b0;
			col <= '0;
			laneAdd <= '0;
		end
		else
		begin
			// add strobe lasts one cycle
			laneAdd <= '0;
			if (accept)
			begin
				pixelAck <= 1'b1;
				laneAdd[laneSel] <= 1'b1;
				if (lastCol)
				begin
					col <= '0;
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
			else if (pixelAck && !pixelReq)
			begin
				// return to zero phase
				pixelAck <= 1'b0;
			end
		end
	end

	// pixel travels with the add strobe
	always_ff @(posedge Clock)
	begin
		if (accept)
		begin
			laneData <= pixelIn;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// ack only answers a pending request
	ackNeedsReq: assert property (
		@(posedge Clock) disable iff (!rstN)
		$rose(pixelAck) |-> $past(pixelReq)
	);

endmodule

/* verilog/poolingLane.sv */
module poolingLane
(
	input  logic Clock,
	input  logic rstN,

	input  logic add,
	input  logic [pixelFormatPkg::pixelWidth-1:0] data,

	output logic ready,

	output logic valid,
	output logic [pixelFormatPkg::pixelWidth-1:0] avg,

	input  logic take
);

	logic [pixelFormatPkg::sumWidth-1:0] acc;
	logic [pixelFormatPkg::sumWidth-1:0] accNext;
	logic [1:0] addCount;
	logic closing;

	//////////////////////////////////////////////////////////////////////
	// window sum
	//////////////////////////////////////////////////////////////////////

	assign accNext = acc + pixelFormatPkg::sumWidth'(data);

	// fourth pixel of the 2x2 window
	assign closing = add && (addCount == 2'd3);

	// a closing add would overwrite an unread result
	assign ready = !(valid && (addCount == 2'd3));

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			acc <= '0;
			addCount <= 2'd0;
			valid <= 1'b0;
		end
		else
		begin
			if (closing)
			begin
				// next window starts from zero while the result waits
				acc <= '0;
				addCount <= 2'd0;
				valid <= 1'b1;
			end
			else
			begin
				if (add)
				begin
					acc <= accNext;
					addCount <= addCount + 2'd1;
				end
				if (take)
				begin
					valid <= 1'b0;
				end
			end
		end
	end

	// floor of sum / 4
	always_ff @(posedge Clock)
	begin
		if (closing)
		begin
			avg <= accNext[pixelFormatPkg::sumWidth-1:pixelFormatPkg::avgShift];
		end
	end

	// sequencer only takes a finished result
	takeWhileValid: assert property (
		@(posedge Clock) disable iff (!rstN)
		take |-> valid
	);

endmodule

/* verilog/poolOutputSequencer.sv */
module poolOutputSequencer
(
	input  logic Clock,
	input  logic rstN,

	input  logic [poolGeometryPkg::laneCount-1:0] laneValid,
	input  logic [poolGeometryPkg::laneCount*pixelFormatPkg::pixelWidth-1:0] laneAvg,
	output logic [poolGeometryPkg::laneCount-1:0] laneTake,

	output logic [pixelFormatPkg::pixelWidth-1:0] outPixel,
	output logic outLast,
	output logic outReq,
	input  logic outAck
);

	logic [poolGeometryPkg::laneSelWidth-1:0] laneSel;
	logic [poolGeometryPkg::outCountWidth-1:0] outCount;
	logic waitAckLow;
	logic load;
	logic lastLane;
	logic lastPixel;

	//////////////////////////////////////////////////////////////////////
	// lane selection
	//////////////////////////////////////////////////////////////////////

	// idle and the current lane has a result
	assign load = !outReq && !waitAckLow && laneValid[laneSel];

	assign lastLane = (laneSel ==
		poolGeometryPkg::laneSelWidth'(poolGeometryPkg::laneCount - 1));

	assign lastPixel = (outCount ==
		poolGeometryPkg::outCountWidth'(poolGeometryPkg::outPixelsPerFrame - 1));

	//////////////////////////////////////////////////////////////////////
	// output handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			laneSel <= '0;
			outCount <= '0;
			outReq <= 1'b0;
			outLast <= 1'b0;
			waitAckLow <= 1'b0;
			laneTake <= '0;
		end
		else
		begin
			laneTake <= '0;
			if (load)
			begin
				outReq <= 1'b1;
				outLast <= lastPixel;
			end
			else if (outReq && outAck)
			begin
				// free the lane as the request drops
				outReq <= 1'b0;
				waitAckLow <= 1'b1;
				laneTake[laneSel] <= 1'b1;
			end
			else if (waitAckLow && !outAck)
			begin
				waitAckLow <= 1'b0;
				outLast <= 1'b0;
				if (lastLane)
				begin
					laneSel <= '0;
				end
				else
				begin
					laneSel <= laneSel + 1'b1;
				end
				// frame wraps with no gap
				if (lastPixel)
				begin
					outCount <= '0;
				end
				else
				begin
					outCount <= outCount + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge Clock)
	begin
		if (load)
		begin
			outPixel <= laneAvg[laneSel*pixelFormatPkg::pixelWidth +: pixelFormatPkg::pixelWidth];
		end
	end

	// data held for the whole request phase
	outStable: assert property (
		@(posedge Clock) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable(outPixel) && $stable(outLast)
	);

endmodule

/* verilog/avgPool2x2.sv */
module avgPool2x2
(
	input  logic Clock,
	input  logic rstN,

	input  logic [pixelFormatPkg::pixelWidth-1:0] pixelIn,
	input  logic pixelReq,
	output logic pixelAck,

	output logic [pixelFormatPkg::pixelWidth-1:0] outPixel,
	output logic outLast,
	output logic outReq,
	input  logic outAck
);

	logic [poolGeometryPkg::laneCount-1:0] laneAdd;
	logic [poolGeometryPkg::laneCount-1:0] laneReady;
	logic [poolGeometryPkg::laneCount-1:0] laneValid;
	logic [poolGeometryPkg::laneCount-1:0] laneTake;
	logic [pixelFormatPkg::pixelWidth-1:0] laneData;
	logic [poolGeometryPkg::laneCount*pixelFormatPkg::pixelWidth-1:0] laneAvg;

	rasterScanner i_rasterScanner
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.pixelIn   (pixelIn),
		.pixelReq  (pixelReq),
		.pixelAck  (pixelAck),
		.laneAdd   (laneAdd),
		.laneData  (laneData),
		.laneReady (laneReady)
	);

	// one lane per output column
	for (genvar i = 0; i < poolGeometryPkg::laneCount; i++)
	begin : gLane
		poolingLane i_poolingLane
		(
			.Clock (Clock),
			.rstN  (rstN),
			.add   (laneAdd[i]),
			.data  (laneData),
			.ready (laneReady[i]),
			.valid (laneValid[i]),
			.avg   (laneAvg[i*pixelFormatPkg::pixelWidth +: pixelFormatPkg::pixelWidth]),
			.take  (laneTake[i])
		);
	end

	poolOutputSequencer i_poolOutputSequencer
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.laneValid (laneValid),
		.laneAvg   (laneAvg),
		.laneTake  (laneTake),
		.outPixel  (outPixel),
		.outLast   (outLast),
		.outReq    (outReq),
		.outAck    (outAck)
	);

endmodule

/* include/avgPoolChecks.svh */
`ifndef AVG_POOL_CHECKS_SVH
`define AVG_POOL_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// result counters
//////////////////////////////////////////////////////////////////////

int checks;
int errors;
int testsRun;
int testsFailed;
int errorsAtStart;
string testName;

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic comparePixel(input string name,
	input logic [pixelFormatPkg::pixelWidth-1:0] got,
	input logic [pixelFormatPkg::pixelWidth-1:0] exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	end
endtask

task automatic compareFlag(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	end
endtask

task automatic compareCount(input string name,
	input logic [poolGeometryPkg::outCountWidth-1:0] got,
	input logic [poolGeometryPkg::outCountWidth-1:0] exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	end
endtask

// failures that are not a wrong value
task automatic failNote(input string msg);
	errors++;
	$display("error: %s", msg);
endtask

task automatic beginTest(input string name);
	testName = name;
	errorsAtStart = errors;
	testsRun++;
endtask

task automatic endTest();
	if (errors == errorsAtStart)
	begin
		$display("test %s: ok", testName);
	end
	else
	begin
		testsFailed++;
		$display("test %s: %0d errors", testName, errors - errorsAtStart);
	end
endtask

`endif

/* testbench/avgPoolTb.sv */
module avgPoolTb;

	localparam int modeRandom = 0;
	localparam int modeFull = 1;
	localparam int modeAlternate = 2;
	localparam int totalFrames = 7;
	localparam int settleCycles = 40;
	localparam int watchdogCycles =
		totalFrames * poolGeometryPkg::frameWidth * poolGeometryPkg::frameHeight * 4 +
		totalFrames * poolGeometryPkg::outPixelsPerFrame * 24 + 1000;

	logic Clock = 1'b0;
	logic rstN;
	logic [pixelFormatPkg::pixelWidth-1:0] pixelIn;
	logic pixelReq;
	logic pixelAck;
	logic [pixelFormatPkg::pixelWidth-1:0] outPixel;
	logic outLast;
	logic outReq;
	logic outAck;

	int seed;
	int ackSeed;
	int ackDelay;
	logic slowAck;
	logic [poolGeometryPkg::outCountWidth-1:0] frameOutCount;

	logic [pixelFormatPkg::pixelWidth-1:0] frame
		[poolGeometryPkg::frameHeight][poolGeometryPkg::frameWidth];
	logic [pixelFormatPkg::pixelWidth-1:0] expPixel [$];
	logic expLast [$];

	`include "avgPoolChecks.svh"

	avgPool2x2 i_avgPool2x2
	(
		.Clock    (Clock),
		.rstN     (rstN),
		.pixelIn  (pixelIn),
		.pixelReq (pixelReq),
		.pixelAck (pixelAck),
		.outPixel (outPixel),
		.outLast  (outLast),
		.outReq   (outReq),
		.outAck   (outAck)
	);

	always #50 Clock = ~Clock;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// floor of each 2x2 window mean in raster order
	task automatic modelFrame();
		logic [pixelFormatPkg::sumWidth-1:0] sum;
		for (int r = 0; r < poolGeometryPkg::outRows; r++)
		begin
			for (int c = 0; c < poolGeometryPkg::laneCount; c++)
			begin
				sum = pixelFormatPkg::sumWidth'(frame[2*r][2*c]) +
					pixelFormatPkg::sumWidth'(frame[2*r][2*c+1]) +
					pixelFormatPkg::sumWidth'(frame[2*r+1][2*c]) +
					pixelFormatPkg::sumWidth'(frame[2*r+1][2*c+1]);
				expPixel.push_back(pixelFormatPkg::pixelWidth'(sum >> pixelFormatPkg::avgShift));
				expLast.push_back(r * poolGeometryPkg::laneCount + c ==
					poolGeometryPkg::outPixelsPerFrame - 1);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////////////////////////

	task automatic sendPixel(input logic [pixelFormatPkg::pixelWidth-1:0] value);
		while (pixelAck)
			@(negedge Clock);
		pixelIn = value;
		pixelReq = 1'b1;
		@(negedge Clock);
		while (!pixelAck)
			@(negedge Clock);
		pixelReq = 1'b0;
		@(negedge Clock);
	endtask

	task automatic sendFrame(input int mode);
		for (int r = 0; r < poolGeometryPkg::frameHeight; r++)
		begin
			for (int c = 0; c < poolGeometryPkg::frameWidth; c++)
			begin
				case (mode)
					modeRandom: frame[r][c] = pixelFormatPkg::pixelWidth'($random(seed));
					modeFull: frame[r][c] = '1;
					default: frame[r][c] = ((r * poolGeometryPkg::frameWidth + c) % 2 == 0) ?
						'1 : pixelFormatPkg::pixelWidth'(1);
				endcase
			end
		end
		modelFrame();
		for (int r = 0; r < poolGeometryPkg::frameHeight; r++)
			for (int c = 0; c < poolGeometryPkg::frameWidth; c++)
				sendPixel(frame[r][c]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// output side
	//////////////////////////////////////////////////////////////////////

	task automatic collectOutput();
		if (expPixel.size() == 0)
		begin
			failNote("output pixel arrived with no expected value");
		end
		else
		begin
			comparePixel("outPixel", outPixel, expPixel.pop_front());
			compareFlag("outLast", outLast, expLast.pop_front());
		end
		frameOutCount = frameOutCount + 1'b1;
		if (outLast)
		begin
			compareCount("frame output count", frameOutCount,
				poolGeometryPkg::outCountWidth'(poolGeometryPkg::outPixelsPerFrame));
			frameOutCount = '0;
		end
	endtask

	// four-phase receiver with an optional random ack delay
	task automatic runCollector();
		forever
		begin
			@(negedge Clock);
			if (!slowAck)
				ackDelay = 0;
			if (outAck && !outReq)
			begin
				outAck = 1'b0;
			end
			else if (!outAck && outReq && rstN)
			begin
				if (ackDelay > 0)
				begin
					ackDelay = ackDelay - 1;
				end
				else
				begin
					collectOutput();
					outAck = 1'b1;
					if (slowAck)
						ackDelay = $unsigned($random(ackSeed)) % 21;
				end
			end
		end
	endtask

	task automatic waitDrain();
		while (expPixel.size() != 0)
			@(negedge Clock);
		// any extra output shows up here
		repeat (settleCycles) @(negedge Clock);
	endtask

	task automatic checkIdle();
		compareFlag("pixelAck", pixelAck, 1'b0);
		compareFlag("outReq", outReq, 1'b0);
		compareFlag("outLast", outLast, 1'b0);
	endtask

	initial
	begin
		repeat (watchdogCycles) @(posedge Clock);
		$display("timeout: outputs still missing after %0d cycles", watchdogCycles);
		$display("sim failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rstN = 1'b0;
		pixelIn = '0;
		pixelReq = 1'b0;
		outAck = 1'b0;
		slowAck = 1'b0;
		ackDelay = 0;
		frameOutCount = '0;
		seed = 32'hf4aa_9c81;
		ackSeed = 32'hf4aa_9c81;
		fork
			runCollector();
		join_none

		beginTest("reset state");
		repeat (4)
		begin
			@(negedge Clock);
			checkIdle();
		end
		rstN = 1'b1;
		@(negedge Clock);
		checkIdle();
		endTest();

		beginTest("single random frame");
		sendFrame(modeRandom);
		waitDrain();
		endTest();

		beginTest("full-scale pixels");
		sendFrame(modeFull);
		sendFrame(modeAlternate);
		waitDrain();
		endTest();

		beginTest("output back-pressure");
		slowAck = 1'b1;
		sendFrame(modeRandom);
		waitDrain();
		slowAck = 1'b0;
		endTest();

		beginTest("back-to-back frames");
		sendFrame(modeRandom);
		sendFrame(modeRandom);
		sendFrame(modeRandom);
		waitDrain();
		endTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* avgPool2x2.f */
+incdir+include
verilog/poolGeometryPkg.sv
verilog/pixelFormatPkg.sv
verilog/rasterScanner.sv
verilog/poolingLane.sv
verilog/poolOutputSequencer.sv
verilog/avgPool2x2.sv
testbench/avgPoolTb.sv

/* Makefile */
# Verilator build and run for the 2x2 average-pooling unit

SOURCES = avgPool2x2.f $(wildcard verilog/*.sv) testbench/avgPoolTb.sv \
	include/avgPoolChecks.svh

.PHONY: all compile run clean

all: run

compile: obj_dir/avgPoolSim

obj_dir/avgPoolSim: $(SOURCES)
	verilator --binary --assert --top-module avgPoolTb -f avgPool2x2.f \
		--Mdir obj_dir -o avgPoolSim

# the log decides pass or fail
run: compile
	-./obj_dir/avgPoolSim > sim.log 2>&1
	@cat sim.log
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
